//--- design/memStage_defs.svh
`ifndef MEMSTAGE_DEFS_SVH
`define MEMSTAGE_DEFS_SVH

////////////////////////////////////////
// Load and store opcodes
////////////////////////////////////////

`define OPCODE_LB  6'h20
`define OPCODE_LH  6'h21
`define OPCODE_LW  6'h23
`define OPCODE_LBU 6'h24
`define OPCODE_LHU 6'h25
`define OPCODE_SB  6'h28
`define OPCODE_SH  6'h29
`define OPCODE_SW  6'h2b

// Address error codes for loads and stores
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5

////////////////////////////////////////
// Address map
////////////////////////////////////////

`define DM_MIN   32'h0000_0000
`define DM_MAX   32'h0000_2fff

`define DEV0_MIN 32'h0000_7f00
`define DEV0_MAX 32'h0000_7f0b
`define DEV1_MIN 32'h0000_7f10
`define DEV1_MAX 32'h0000_7f1b

// Device registers that are read-only
`define NOWRITE0 32'h0000_7f08
`define NOWRITE1 32'h0000_7f18

// Data memory depth in words
`define DM_WORDS 3072

// Window test by offset, so a zero lower bound needs no special case
`define IN_RANGE(a, lo, hi) ((((a) - (lo))) <= (((hi) - (lo))))

`endif

//--- design/memStagePkg.sv
package memStagePkg;

	// Width of a memory access
	typedef enum logic [1:0]
	{
		sizeNone = 2'd0,
		sizeByte = 2'd1,
		sizeHalf = 2'd2,
		sizeWord = 2'd3
	} accessSize_t;

	// Decoded view of a load or store
	typedef struct packed
	{
		logic        isLoad;
		logic        isStore;
		accessSize_t size;
		logic        signExtend;
	} accessInfo_t;

	////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////

	// Request from execute
	typedef struct packed
	{
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
		logic [31:0] addr;
		logic [31:0] storeData;
		logic        excGet;
		logic [4:0]  excCode;
	} memReq_t;

	// Outcome toward write-back
	typedef struct packed
	{
		logic        valid;
		logic [31:0] pc;
		logic        excGet;
		logic [4:0]  excCode;
		logic        isLoad;
		logic [31:0] loadData;
	} memResult_t;

endpackage

//--- design/stageRegister.sv
`timescale 1ns/1ps

module stageRegister #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  payload_t d,
	output payload_t q
);

	// Zero payload carries valid low, so a cleared stage is empty
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			q <= '0;
		end
		else if (!stall)
		begin
			q <= d;
		end
		// Hold while stalled
	end

endmodule

//--- design/accessDecoder.sv
`timescale 1ns/1ps
`include "memStage_defs.svh"

module accessDecoder (
	input  logic [5:0]               opcode,
	output memStagePkg::accessInfo_t access
);

	import memStagePkg::*;

	always_comb
	begin
		// Not a memory op unless matched below
		access = '{isLoad: 1'b0, isStore: 1'b0, size: sizeNone, signExtend: 1'b0};
		case (opcode)
			`OPCODE_LB:
			begin
				access = '{isLoad: 1'b1, isStore: 1'b0, size: sizeByte, signExtend: 1'b1};
			end
			`OPCODE_LBU:
			begin
				access = '{isLoad: 1'b1, isStore: 1'b0, size: sizeByte, signExtend: 1'b0};
			end
			`OPCODE_LH:
			begin
				access = '{isLoad: 1'b1, isStore: 1'b0, size: sizeHalf, signExtend: 1'b1};
			end
			`OPCODE_LHU:
			begin
				access = '{isLoad: 1'b1, isStore: 1'b0, size: sizeHalf, signExtend: 1'b0};
			end
			`OPCODE_LW:
			begin
				access = '{isLoad: 1'b1, isStore: 1'b0, size: sizeWord, signExtend: 1'b0};
			end
			// Stores never extend
			`OPCODE_SB:
			begin
				access = '{isLoad: 1'b0, isStore: 1'b1, size: sizeByte, signExtend: 1'b0};
			end
			`OPCODE_SH:
			begin
				access = '{isLoad: 1'b0, isStore: 1'b1, size: sizeHalf, signExtend: 1'b0};
			end
			`OPCODE_SW:
			begin
				access = '{isLoad: 1'b0, isStore: 1'b1, size: sizeWord, signExtend: 1'b0};
			end
			default:
			begin
			end
		endcase
	end

endmodule

//--- design/memExcChecker.sv
`timescale 1ns/1ps
`include "memStage_defs.svh"

module memExcChecker (
	input  memStagePkg::accessInfo_t access,
	input  logic [31:0]              addr,
	input  logic                     preExcGet,
	input  logic [4:0]               preExcCode,
	output logic                     excGet,
	output logic [4:0]               excCode
);

	import memStagePkg::*;

	logic memOp;
	logic halfMisaligned;
	logic wordMisaligned;
	logic inDm;
	logic inDev;
	logic noWriteAddr;
	logic badDevSize;
	logic newExc;

	////////////////////////////////////////
	// Individual rules
	////////////////////////////////////////

	assign memOp = access.isLoad | access.isStore;

	// Alignment from the low address bits
	assign halfMisaligned = (access.size == sizeHalf) && addr[0];
	assign wordMisaligned = (access.size == sizeWord) && (addr[1:0] != 2'b00);

	assign inDm  = `IN_RANGE(addr, `DM_MIN, `DM_MAX);
	assign inDev = `IN_RANGE(addr, `DEV0_MIN, `DEV0_MAX)
		|| `IN_RANGE(addr, `DEV1_MIN, `DEV1_MAX);

	assign noWriteAddr = (addr == `NOWRITE0) || (addr == `NOWRITE1);

	// Devices take whole words only
	assign badDevSize = inDev && (access.size != sizeWord);

	assign newExc = memOp && (halfMisaligned
		|| wordMisaligned
		|| !(inDm || inDev)
		|| (access.isStore && noWriteAddr)
		|| badDevSize);

	////////////////////////////////////////
	// Merge with earlier stages
	////////////////////////////////////////

	assign excGet = preExcGet | newExc;

	always_comb
	begin
		if (preExcGet)
		begin
			excCode = preExcCode;
		end
		else if (newExc)
		begin
			// Direction picks the code
			excCode = access.isStore ? `EXC_ADES : `EXC_ADEL;
		end
		else
		begin
			excCode = 5'd0;
		end
	end

endmodule

//--- design/dataMemory.sv
`timescale 1ns/1ps
`include "memStage_defs.svh"

module dataMemory (
	input  logic                     clk,
	input  logic                     reset,
	input  memStagePkg::accessInfo_t access,
	input  logic [31:0]              addr,
	input  logic [31:0]              storeData,
	input  logic                     writeEnable,
	input  logic [31:0]              devRData,
	output logic [31:0]              loadData,
	output logic                     devWrite,
	output logic [31:0]              devAddr,
	output logic [31:0]              devWData
);

	import memStagePkg::*;

	localparam int IdxBits = $clog2(`DM_WORDS);

	logic [31:0]        mem [`DM_WORDS];
	logic [IdxBits-1:0] wordIdx;
	logic               inDm;
	logic               inDev;
	logic               memWrite;
	logic [3:0]         byteEn;
	logic [31:0]        laneData;
	logic [31:0]        rdWord;
	logic [7:0]         rdByte;
	logic [15:0]        rdHalf;

	assign wordIdx = addr[IdxBits+1:2];
	assign inDm    = `IN_RANGE(addr, `DM_MIN, `DM_MAX);
	assign inDev   = `IN_RANGE(addr, `DEV0_MIN, `DEV0_MAX)
		|| `IN_RANGE(addr, `DEV1_MIN, `DEV1_MAX);

	////////////////////////////////////////
	// Store path
	////////////////////////////////////////

	// Replicate low lanes so any enabled lane sees the right bytes
	always_comb
	begin
		case (access.size)
			sizeByte:
			begin
				byteEn   = 4'b0001 << addr[1:0];
				laneData = {4{storeData[7:0]}};
			end
			sizeHalf:
			begin
				byteEn   = addr[1] ? 4'b1100 : 4'b0011;
				laneData = {2{storeData[15:0]}};
			end
			sizeWord:
			begin
				byteEn   = 4'b1111;
				laneData = storeData;
			end
			default:
			begin
				byteEn   = 4'b0000;
				laneData = storeData;
			end
		endcase
	end

	assign memWrite = writeEnable && access.isStore && inDm;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `DM_WORDS; i++)
			begin
				mem[i] <= 32'd0;
			end
		end
		else if (memWrite)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (byteEn[b])
				begin
					mem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
				end
			end
		end
	end

	// Device window goes out on the port
	assign devWrite = writeEnable && access.isStore && inDev;
	assign devAddr  = addr;
	assign devWData = storeData;

	////////////////////////////////////////
	// Load path
	////////////////////////////////////////

	always_comb
	begin
		if (inDev)
		begin
			rdWord = devRData;
		end
		else if (inDm)
		begin
			rdWord = mem[wordIdx];
		end
		else
		begin
			rdWord = 32'd0;
		end
	end

	assign rdByte = rdWord[{addr[1:0], 3'b000} +: 8];
	assign rdHalf = addr[1] ? rdWord[31:16] : rdWord[15:0];

	always_comb
	begin
		case (access.size)
			sizeByte: loadData = {{24{access.signExtend & rdByte[7]}}, rdByte};
			sizeHalf: loadData = {{16{access.signExtend & rdHalf[15]}}, rdHalf};
			sizeWord: loadData = rdWord;
			default:  loadData = 32'd0;
		endcase
	end

endmodule

//--- design/memStage.sv
`timescale 1ns/1ps

module memStage (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stall,
	input  memStagePkg::memReq_t    req,
	input  logic [31:0]             devRData,
	output memStagePkg::memResult_t result,
	output logic                    devWrite,
	output logic [31:0]             devAddr,
	output logic [31:0]             devWData
);

	import memStagePkg::*;

	memReq_t     curReq;
	accessInfo_t access;
	logic        excGet;
	logic [4:0]  excCode;
	logic        writeEnable;
	logic [31:0] loadData;
	memResult_t  stageResult;

	////////////////////////////////////////
	// Execute to memory
	////////////////////////////////////////

	stageRegister #(.payload_t(memReq_t)) inReg (
		.clk   (clk),
		.reset (reset),
		.stall (stall),
		.d     (req),
		.q     (curReq)
	);

	accessDecoder decoder (
		.opcode (curReq.instr[31:26]),
		.access (access)
	);

	memExcChecker excCheck (
		.access     (access),
		.addr       (curReq.addr),
		.preExcGet  (curReq.excGet),
		.preExcCode (curReq.excCode),
		.excGet     (excGet),
		.excCode    (excCode)
	);

	// No side effects for faulting, stalled or empty slots
	assign writeEnable = curReq.valid & ~excGet & ~stall;

	dataMemory dmem (
		.clk         (clk),
		.reset       (reset),
		.access      (access),
		.addr        (curReq.addr),
		.storeData   (curReq.storeData),
		.writeEnable (writeEnable),
		.devRData    (devRData),
		.loadData    (loadData),
		.devWrite    (devWrite),
		.devAddr     (devAddr),
		.devWData    (devWData)
	);

	////////////////////////////////////////
	// Memory to write-back
	////////////////////////////////////////

	assign stageResult = '{valid: curReq.valid, pc: curReq.pc, excGet: excGet,
		excCode: excCode, isLoad: access.isLoad, loadData: loadData};

	stageRegister #(.payload_t(memResult_t)) outReg (
		.clk   (clk),
		.reset (reset),
		.stall (stall),
		.d     (stageResult),
		.q     (result)
	);

endmodule

//--- test/memStage_tb.sv
`timescale 1ns/1ps
`include "memStage_defs.svh"

module memStage_tb;

	import memStagePkg::*;

	localparam int NumReqs        = 600;
	localparam int ClkPeriod      = 8;
	localparam int WatchdogCycles = NumReqs * 4 + 100;
	localparam logic [5:0] OpTable [9] = '{`OPCODE_LB, `OPCODE_LH, `OPCODE_LW, `OPCODE_LBU,
		`OPCODE_LHU, `OPCODE_SB, `OPCODE_SH, `OPCODE_SW, 6'h0f};

	logic        clk;
	logic        reset;
	logic        stall;
	memReq_t     req;
	logic [31:0] devRData;
	memResult_t  result;
	logic        devWrite;
	logic [31:0] devAddr;
	logic [31:0] devWData;

	logic [31:0] lfsrState = 32'h570d278a;
	logic [31:0] shadowMem [`DM_WORDS];
	memResult_t  expQ [$];
	memReq_t     curModel;
	memResult_t  lastResult;
	logic        freshResult = 1'b0;
	logic        wasReset = 1'b1;
	int          accepted = 0;

	memStage u_dut (
		.clk      (clk),
		.reset    (reset),
		.stall    (stall),
		.req      (req),
		.devRData (devRData),
		.result   (result),
		.devWrite (devWrite),
		.devAddr  (devAddr),
		.devWData (devWData)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	////////////////////////////////////////
	// Random source
	////////////////////////////////////////

	function automatic logic stepLfsr();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
		begin
			lfsrState ^= 32'h8020_0003;
		end
		return outBit;
	endfunction

	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], stepLfsr()};
		end
		return v;
	endfunction

	////////////////////////////////////////
	// Access rules
	////////////////////////////////////////

	function automatic int opSize(input logic [5:0] op);
		if (op == `OPCODE_LB || op == `OPCODE_LBU || op == `OPCODE_SB)
		begin
			return 1;
		end
		else if (op == `OPCODE_LH || op == `OPCODE_LHU || op == `OPCODE_SH)
		begin
			return 2;
		end
		else if (op == `OPCODE_LW || op == `OPCODE_SW)
		begin
			return 4;
		end
		return 0;
	endfunction

	function automatic logic isStoreOp(input logic [5:0] op);
		return op inside {`OPCODE_SB, `OPCODE_SH, `OPCODE_SW};
	endfunction

	function automatic logic inDmWindow(input logic [31:0] a);
		return a <= `DM_MAX;
	endfunction

	function automatic logic inDevWindow(input logic [31:0] a);
		return (a >= `DEV0_MIN && a <= `DEV0_MAX) || (a >= `DEV1_MIN && a <= `DEV1_MAX);
	endfunction

	// Expected outcome of one request against the shadow memory
	function automatic memResult_t expectResult(input memReq_t r, input logic [31:0] devData);
		memResult_t  e;
		logic [5:0]  op;
		logic        isLoad;
		logic        isStore;
		logic        bad;
		int          size;
		logic [31:0] word;
		logic [31:0] lane;
		op      = r.instr[31:26];
		size    = opSize(op);
		isStore = isStoreOp(op);
		isLoad  = (size != 0) && !isStore;
		bad = (size == 2 && r.addr[0]) || (size == 4 && r.addr[1:0] != 2'b00)
			|| !(inDmWindow(r.addr) || inDevWindow(r.addr))
			|| (isStore && (r.addr == `NOWRITE0 || r.addr == `NOWRITE1))
			|| (inDevWindow(r.addr) && size != 4);
		e = '0;
		e.valid  = r.valid;
		e.pc     = r.pc;
		e.isLoad = isLoad;
		if (r.excGet)
		begin
			e.excGet  = 1'b1;
			e.excCode = r.excCode;
		end
		else if (size != 0 && bad)
		begin
			e.excGet  = 1'b1;
			e.excCode = isStore ? `EXC_ADES : `EXC_ADEL;
		end
		word = inDevWindow(r.addr) ? devData
			: (inDmWindow(r.addr) ? shadowMem[r.addr[13:2]] : 32'd0);
		lane = word >> (8 * r.addr[1:0]);
		// Signed forms are LB and LH only
		if (size == 1)
		begin
			e.loadData = (op == `OPCODE_LB) ? {{24{lane[7]}}, lane[7:0]} : {24'd0, lane[7:0]};
		end
		else if (size == 2)
		begin
			e.loadData = (op == `OPCODE_LH) ? {{16{lane[15]}}, lane[15:0]} : {16'd0, lane[15:0]};
		end
		else
		begin
			e.loadData = word;
		end
		return e;
	endfunction

	task automatic writeShadow(input memReq_t r);
		int lanePos;
		for (int b = 0; b < opSize(r.instr[31:26]); b++)
		begin
			lanePos = r.addr[1:0] + b;
			shadowMem[r.addr[13:2]][8*lanePos +: 8] = r.storeData[8*b +: 8];
		end
	endtask

	////////////////////////////////////////
	// Stimulus generation
	////////////////////////////////////////

	function automatic logic [31:0] pickAddress(input logic [5:0] op);
		logic [31:0] a;
		logic [2:0]  cls;
		cls = 3'(takeBits(3));
		if (cls <= 3'd4)
		begin
			// Two small regions, so loads often hit earlier stores
			a = takeBits(1) ? 32'h0000_2fc0 : 32'h0000_0100;
			a += takeBits(4) << 2;
			if (cls == 3'd4)
			begin
				a += (takeBits(1) << 1) | 32'd1;
			end
			else
			begin
				a += takeBits(2);
				if (opSize(op) == 2)
				begin
					a[0] = 1'b0;
				end
				else if (opSize(op) == 4)
				begin
					a[1:0] = 2'b00;
				end
			end
		end
		else if (cls == 3'd5)
		begin
			a = takeBits(1) ? `DEV1_MIN : `DEV0_MIN;
			a += (takeBits(2) % 3) * 4;
			if (takeBits(1))
			begin
				a += takeBits(2);
			end
		end
		else if (cls == 3'd6)
		begin
			a = takeBits(1) ? `NOWRITE1 : `NOWRITE0;
		end
		else
		begin
			case (takeBits(2))
				0: a = 32'h0000_3000 + (takeBits(4) << 2);
				1: a = 32'h0000_7f0c;
				2: a = 32'h0000_7f1c;
				default: a = 32'hffff_fffc;
			endcase
		end
		return a;
	endfunction

	function automatic memReq_t makeRequest(input logic [31:0] pc);
		memReq_t r;
		r.valid = (takeBits(3) != 0);
		r.pc    = pc;
		r.instr = takeBits(32);
		r.instr[31:26] = OpTable[takeBits(4) % 9];
		r.addr      = pickAddress(r.instr[31:26]);
		r.storeData = takeBits(32);
		r.excGet    = (takeBits(4) == 0);
		r.excCode   = r.excGet ? 5'(takeBits(5)) : 5'd0;
		return r;
	endfunction

	initial
	begin
		memReq_t r;
		logic    stallNow;
		int      seq;
		clk      = 1'b0;
		reset    = 1'b1;
		stall    = 1'b0;
		req      = '0;
		devRData = '0;
		seq      = 0;
		for (int i = 0; i < `DM_WORDS; i++)
		begin
			shadowMem[i] = 32'd0;
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		while (accepted < NumReqs)
		begin
			stallNow = (takeBits(2) == 3);
			r = makeRequest(seq << 2);
			seq++;
			req      <= r;
			stall    <= stallNow;
			devRData <= takeBits(32);
			if (r.valid && !stallNow)
			begin
				accepted++;
			end
			@(posedge clk);
		end
		req   <= '0;
		stall <= 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (expQ.size() == 0)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
		begin
			$display("%0d of %0d accepted requests never produced a result",
				expQ.size(), accepted);
			$display("Simulation FAILED");
			$fatal(1, "missing results");
		end
	end

	initial
	begin
		#(WatchdogCycles * ClkPeriod);
		$display("Watchdog expired, results stopped arriving");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	////////////////////////////////////////
	// Model and compare
	////////////////////////////////////////

	// Follows the input register and queues each outcome as it leaves
	always @(posedge clk)
	begin
		memResult_t e;
		wasReset = reset;
		if (reset)
		begin
			curModel    = '0;
			freshResult = 1'b0;
		end
		else if (stall)
		begin
			freshResult = 1'b0;
		end
		else
		begin
			freshResult = 1'b1;
			if (curModel.valid)
			begin
				e = expectResult(curModel, devRData);
				expQ.push_back(e);
				if (!e.excGet && isStoreOp(curModel.instr[31:26]) && inDmWindow(curModel.addr))
				begin
					writeShadow(curModel);
				end
			end
			curModel = req;
		end
	end

	task automatic checkValue(input string name, input logic [71:0] expected,
		input logic [71:0] actual);
		if (expected !== actual)
		begin
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	always @(negedge clk)
	begin
		memResult_t expected;
		memResult_t cur;
		logic       expDev;
		if (!wasReset)
		begin
			if (!freshResult)
			begin
				checkValue("result (stalled)", lastResult, result);
			end
			else if (result.valid)
			begin
				if (expQ.size() == 0)
				begin
					$display("Result for pc %h arrived with no request outstanding", result.pc);
					$display("Simulation FAILED");
					$fatal(1, "unexpected result");
				end
				else
				begin
					expected = expQ.pop_front();
					checkValue("result.pc", 72'(expected.pc), 72'(result.pc));
					checkValue("result.excGet", 72'(expected.excGet), 72'(result.excGet));
					checkValue("result.excCode", 72'(expected.excCode), 72'(result.excCode));
					checkValue("result.isLoad", 72'(expected.isLoad), 72'(result.isLoad));
					if (expected.isLoad && !expected.excGet)
					begin
						checkValue("result.loadData", 72'(expected.loadData),
							72'(result.loadData));
					end
				end
			end
			// Device strobe for the request now in the input register
			cur = expectResult(curModel, devRData);
			expDev = curModel.valid && !stall && !cur.excGet
				&& isStoreOp(curModel.instr[31:26]) && inDevWindow(curModel.addr);
			checkValue("devWrite", 72'(expDev), 72'(devWrite));
			if (expDev)
			begin
				checkValue("devAddr", 72'(curModel.addr), 72'(devAddr));
				checkValue("devWData", 72'(curModel.storeData), 72'(devWData));
			end
		end
		lastResult = result;
	end

endmodule

//--- memStage.f
+incdir+design
design/memStagePkg.sv
design/stageRegister.sv
design/accessDecoder.sv
design/memExcChecker.sv
design/dataMemory.sv
design/memStage.sv
test/memStage_tb.sv

//--- Makefile
# Verilator flow for the memory-access stage

VERILATOR   ?= verilator
FILELIST    ?= memStage.f
TB_TOP      ?= memStage_tb
RTL_TOP     ?= memStage
OBJ_DIR     ?= obj_dir
LINT_FLAGS  ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing -j 0
PASS_TEXT   ?= Simulation PASSED

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# Pass only when the simulation output holds the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
